/* logic/fpu_settings.svh */
/*
  Sizing constants for the FPU register subsystem.
  Included by the package and by any module that sizes arrays from them.
*/
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// number of f registers, f0..f31
`define FPU_NUM_REGS 32

// single precision word
`define FPU_XLEN 32

// strobe edge to register-file write edge
`define FPU_PIPE_DEPTH 2

`endif

/* logic/fpu_pkg.sv */
/*
  Shared types for the FPU register subsystem.
  Imported by the RTL and the testbench for word, index and opcode types.
*/
package fpu_pkg;

  `include "fpu_settings.svh"

  typedef logic [`FPU_XLEN-1:0] fp_word_t;                 // IEEE single
  typedef logic [$clog2(`FPU_NUM_REGS)-1:0] freg_idx_t;     // register index
  typedef logic [2:0] frm_t;                                 // rounding mode
  typedef logic [4:0] fflags_t;                              // NV DZ OF UF NX

  typedef enum logic [2:0] {
    FP_NOP   = 3'd0,
    FP_LOAD  = 3'd1,  // flw, data from load_data
    FP_STORE = 3'd2,  // fsw, rs2 out on store_data
    FP_SGNJ  = 3'd3,
    FP_SGNJN = 3'd4,
    FP_SGNJX = 3'd5,
    FP_MIN   = 3'd6,
    FP_MAX   = 3'd7
  } fp_op_t;

  // issue stage holds a valid op or not
  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } fp_stage_t;

endpackage

/* logic/f_register_file_if.sv */
/*
  Port bundle between the writeback stage and the FP register file.
  wb drives the write request and read indices, rf returns read data and fcsr.
*/
`timescale 1ns/100ps

interface f_register_file_if
  import fpu_pkg::*;
(
  input logic frf_rf,  // clock
  input logic reset
);

  // write request, from writeback
  logic      f_LW;      // load write, always commits
  logic      f_SW;      // store, blocks the write
  logic      f_ready;   // compute result valid
  freg_idx_t f_rd;
  fp_word_t  f_w_data;
  fflags_t   flags;     // replaces fcsr flags on write
  frm_t      f_frm_in;  // sampled every cycle

  // read side
  freg_idx_t f_rs1;
  freg_idx_t f_rs2;
  fp_word_t  f_rs1_data;
  fp_word_t  f_rs2_data;
  frm_t      f_frm_out;
  fflags_t   f_flags;

  modport wb (
    output f_LW, f_SW, f_ready, f_rd, f_w_data, flags, f_frm_in,
    output f_rs1, f_rs2
  );

  modport rf (
    input  frf_rf, reset,
    input  f_LW, f_SW, f_ready, f_rd, f_w_data, flags, f_frm_in,
    input  f_rs1, f_rs2,
    output f_rs1_data, f_rs2_data, f_frm_out, f_flags
  );

endinterface

/* logic/fp_issue.sv */
/*
  Issue stage. Takes the op strobe and the combinational register reads,
  picks the operands and registers them for the sign/minmax unit.
*/
`timescale 1ns/100ps

module fp_issue
  import fpu_pkg::*;
(
  input  logic      frf_rf,
  input  logic      reset,
  input  logic      op_valid,
  input  fp_op_t    op,
  input  freg_idx_t rs1,
  input  freg_idx_t rs2,
  input  freg_idx_t rd,
  input  fp_word_t  load_data,
  input  fp_word_t  rs1_data,   // read in the strobe cycle
  input  fp_word_t  rs2_data,
  output logic      ex_valid,
  output fp_op_t    ex_op,
  output freg_idx_t ex_rd,
  output fp_word_t  ex_a,
  output fp_word_t  ex_b
);

  fp_stage_t state;
  logic      take;     // real op this cycle
  fp_word_t  opnd_a;

  assign take = op_valid && (op != FP_NOP);  // nop becomes a bubble

  // load data stands in for rs1 on flw
  assign opnd_a = (op == FP_LOAD) ? load_data : rs1_data;

  always_ff @(posedge frf_rf) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= take ? BUSY : IDLE;  // one op per strobe
    end
  end

  // payload only moves on a real op
  always_ff @(posedge frf_rf) begin
    if (take) begin
      ex_op <= op;
      ex_rd <= rd;
      ex_a  <= opnd_a;
      ex_b  <= rs2_data;  // second operand, also the store data
    end
  end

  assign ex_valid = (state == BUSY);

endmodule

/* logic/fp_sign_minmax.sv */
/*
  Sign injection and IEEE-754-2008 minNum/maxNum, one register stage.
  Loads pass operand a, stores pass operand b. NV flags signaling NaN inputs.
*/
`timescale 1ns/100ps

module fp_sign_minmax
  import fpu_pkg::*;
(
  input  logic      frf_rf,
  input  logic      reset,
  input  logic      ex_valid,
  input  fp_op_t    ex_op,
  input  freg_idx_t ex_rd,
  input  fp_word_t  ex_a,
  input  fp_word_t  ex_b,
  output logic      res_valid,
  output fp_op_t    res_op,
  output freg_idx_t res_rd,
  output fp_word_t  res_data,
  output fflags_t   res_flags
);

  localparam fp_word_t CANON_NAN = 32'h7fc0_0000;

  logic     a_nan, b_nan;
  logic     a_snan, b_snan;
  logic     a_lt_b;       // ordered compare, -0 < +0
  logic     is_minmax;
  fp_word_t mm_data;
  fp_word_t nxt_data;
  fflags_t  nxt_flags;

  // nan: exp all ones, mantissa nonzero; quiet bit is mantissa msb
  assign a_nan  = (&ex_a[30:23]) && (|ex_a[22:0]);
  assign b_nan  = (&ex_b[30:23]) && (|ex_b[22:0]);
  assign a_snan = a_nan && !ex_a[22];
  assign b_snan = b_nan && !ex_b[22];

  always_comb begin
    if (ex_a[31] != ex_b[31])
      a_lt_b = ex_a[31];                  // negative one is smaller
    else if (!ex_a[31])
      a_lt_b = ex_a[30:0] < ex_b[30:0];   // both positive
    else
      a_lt_b = ex_a[30:0] > ex_b[30:0];   // both negative, bigger mag is smaller
  end

  assign is_minmax = (ex_op == FP_MIN) || (ex_op == FP_MAX);

  always_comb begin
    if (a_nan && b_nan)
      mm_data = CANON_NAN;
    else if (a_nan)
      mm_data = ex_b;   // nan loses
    else if (b_nan)
      mm_data = ex_a;
    else if (ex_op == FP_MIN)
      mm_data = a_lt_b ? ex_a : ex_b;
    else
      mm_data = a_lt_b ? ex_b : ex_a;
  end

  always_comb begin
    nxt_flags = '0;
    case (ex_op)
      FP_LOAD:  nxt_data = ex_a;
      FP_STORE: nxt_data = ex_b;
      FP_SGNJ:  nxt_data = {ex_b[31], ex_a[30:0]};
      FP_SGNJN: nxt_data = {~ex_b[31], ex_a[30:0]};
      FP_SGNJX: nxt_data = {ex_a[31] ^ ex_b[31], ex_a[30:0]};
      FP_MIN,
      FP_MAX:   nxt_data = mm_data;
      default:  nxt_data = '0;
    endcase
    nxt_flags[4] = is_minmax && (a_snan || b_snan);  // NV only
  end

  always_ff @(posedge frf_rf) begin
    if (reset) res_valid <= 1'b0;
    else       res_valid <= ex_valid;
  end

  always_ff @(posedge frf_rf) begin
    if (ex_valid) begin
      res_op    <= ex_op;
      res_rd    <= ex_rd;
      res_data  <= nxt_data;
      res_flags <= nxt_flags;
    end
  end

endmodule

/* logic/fp_writeback.sv */
/*
  Output stage. Turns the registered result into the register-file write
  request (f_LW / f_SW / f_ready) and drives the store port.
  Also forwards frm_in and the read indices onto the register-file bundle.
*/
`timescale 1ns/100ps

module fp_writeback
  import fpu_pkg::*;
(
  input  logic      frf_rf,
  input  logic      reset,
  input  logic      res_valid,
  input  fp_op_t    res_op,
  input  freg_idx_t res_rd,
  input  fp_word_t  res_data,
  input  fflags_t   res_flags,
  input  frm_t      frm_in,
  input  freg_idx_t rs1,
  input  freg_idx_t rs2,
  output logic      store_valid,
  output fp_word_t  store_data,
  f_register_file_if.wb wb
);

  logic     is_load;
  logic     is_store;
  fp_word_t store_hold;  // last value stored

  assign is_load  = res_valid && (res_op == FP_LOAD);
  assign is_store = res_valid && (res_op == FP_STORE);

  // write request, commits at the next edge
  assign wb.f_LW     = is_load;
  assign wb.f_SW     = is_store;
  assign wb.f_ready  = res_valid && !is_load && !is_store;
  assign wb.f_rd     = res_rd;
  assign wb.f_w_data = res_data;
  assign wb.flags    = res_flags;   // zero for loads
  assign wb.f_frm_in = frm_in;

  // read indices straight through
  assign wb.f_rs1 = rs1;
  assign wb.f_rs2 = rs2;

  // keep store_data steady between stores
  always_ff @(posedge frf_rf) begin
    if (reset)
      store_hold <= '0;
    else if (is_store)
      store_hold <= res_data;
  end

  assign store_valid = is_store;  // one pulse per store result
  assign store_data  = is_store ? res_data : store_hold;

endmodule

/* logic/f_register_file.sv */
/*
  FP register file with the fcsr rounding mode and flag fields.
  Two combinational read ports, one write port driven from the writeback bundle.
*/
`timescale 1ns/100ps

`include "fpu_settings.svh"

module f_register_file
  import fpu_pkg::*;
(
  f_register_file_if.rf frf_rf
);

  fp_word_t regs [`FPU_NUM_REGS];
  frm_t     frm;
  fflags_t  fflags;
  logic     f_wen;

  // load always writes, compute writes when ready, store never
  always_comb begin
    f_wen = 1'b0;
    if (frf_rf.f_LW)
      f_wen = 1'b1;
    else if (frf_rf.f_ready && !frf_rf.f_SW)
      f_wen = 1'b1;
  end

  always_ff @(posedge frf_rf.frf_rf) begin
    if (frf_rf.reset) begin
      for (int i = 0; i < `FPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      fflags <= '0;
    end else if (f_wen) begin
      regs[frf_rf.f_rd] <= frf_rf.f_w_data;
      fflags            <= frf_rf.flags;  // replace, no accumulate
    end
  end

  // rounding mode follows the input every cycle
  always_ff @(posedge frf_rf.frf_rf) begin
    if (frf_rf.reset) frm <= '0;
    else              frm <= frf_rf.f_frm_in;
  end

  assign frf_rf.f_rs1_data = regs[frf_rf.f_rs1];
  assign frf_rf.f_rs2_data = regs[frf_rf.f_rs2];
  assign frf_rf.f_frm_out  = frm;
  assign frf_rf.f_flags    = fflags;

endmodule

/* logic/fpu_regfile_top.sv */
/*
  Top of the FP register subsystem: issue, sign/minmax, writeback, register file.
  An op strobed at edge N writes the register file at edge N+2.
  rd_idx/rd_data give a debug read through the rs2 port while idle.
*/
`timescale 1ns/100ps

module fpu_regfile_top
  import fpu_pkg::*;
(
  input  logic      frf_rf,
  input  logic      reset,
  input  logic      op_valid,
  input  fp_op_t    op,
  input  freg_idx_t rs1,
  input  freg_idx_t rs2,
  input  freg_idx_t rd,
  input  fp_word_t  load_data,
  input  frm_t      frm_in,
  input  freg_idx_t rd_idx,      // debug read index
  output logic      store_valid,
  output fp_word_t  store_data,
  output frm_t      frm_out,
  output fflags_t   flags_out,
  output fp_word_t  rd_data
);

  logic      ex_valid,  res_valid;
  fp_op_t    ex_op,     res_op;
  freg_idx_t ex_rd,     res_rd;
  fp_word_t  ex_a, ex_b, res_data;
  fflags_t   res_flags;
  freg_idx_t rs2_port;  // rs2 or debug index

  f_register_file_if frf_if (.frf_rf(frf_rf), .reset(reset));

  assign rs2_port = op_valid ? rs2 : rd_idx;  // debug borrows port when idle

  fp_issue u_issue (
    .frf_rf, .reset, .op_valid, .op, .rs1, .rs2, .rd, .load_data,
    .rs1_data (frf_if.f_rs1_data),
    .rs2_data (frf_if.f_rs2_data),
    .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b
  );

  fp_sign_minmax u_sign_minmax (
    .frf_rf, .reset, .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b,
    .res_valid, .res_op, .res_rd, .res_data, .res_flags
  );

  fp_writeback u_writeback (
    .frf_rf, .reset, .res_valid, .res_op, .res_rd, .res_data, .res_flags,
    .frm_in, .rs1, .rs2 (rs2_port), .store_valid, .store_data,
    .wb (frf_if.wb)
  );

  f_register_file u_regfile (.frf_rf(frf_if.rf));

  assign rd_data   = frf_if.f_rs2_data;
  assign frm_out   = frf_if.f_frm_out;
  assign flags_out = frf_if.f_flags;

endmodule

/* dv/fpu_regfile_properties.sv */
/*
  Concurrent checks on the FPU register subsystem top level.
  Bound into fpu_regfile_top, watches the store port, fcsr outputs and RF writes.
*/
`timescale 1ns/100ps

module fpu_regfile_properties
  import fpu_pkg::*;
(
  input logic     frf_rf,
  input logic     reset,
  input logic     store_valid,
  input fp_word_t store_data,
  input frm_t     frm_out,
  input fflags_t  flags_out,
  input logic     rf_wen     // register file write enable
);

  // a store result never shares a cycle with a register write
  store_no_write: assert property (@(posedge frf_rf) disable iff (reset)
    !(store_valid && rf_wen))
    else $error("store_valid high while the register file is being written");

  // everything visible comes out of reset cleared
  reset_clears: assert property (@(posedge frf_rf)
    reset |=> (!store_valid && store_data == '0 && frm_out == '0 && flags_out == '0))
    else $error("outputs not cleared after reset");

  store_pulse: assert property (@(posedge frf_rf) disable iff (reset)
    store_valid |=> !store_valid)  // single-cycle pulse
    else $error("store_valid held for more than one cycle");

endmodule

bind fpu_regfile_top fpu_regfile_properties props (
  .frf_rf      (frf_rf),
  .reset       (reset),
  .store_valid (store_valid),
  .store_data  (store_data),
  .frm_out     (frm_out),
  .flags_out   (flags_out),
  .rf_wen      (u_regfile.f_wen)
);

/* dv/fpu_regfile_tb.sv */
/*
  Vector-driven testbench for the FPU register subsystem.
  Reads dv/fpu_regfile_vectors.txt, runs each op through the DUT and checks
  registers, flags, store data and frm_out against a reference model.
*/
`timescale 1ns/100ps

`include "fpu_settings.svh"

module fpu_regfile_tb
  import fpu_pkg::*;
();

  typedef struct packed {
    fp_op_t     op;
    freg_idx_t  rs1;
    freg_idx_t  rs2;
    freg_idx_t  rd;
    fp_word_t   ld;       // load data
    frm_t       frm;
    logic [7:0] idle;     // idle cycles after the op
    logic [2:0] mode;     // random / model check / expect check
    fp_word_t   exp_val;
  } vec_t;

  logic      frf_rf;
  logic      reset;
  logic      op_valid;
  fp_op_t    op;
  freg_idx_t rs1, rs2, rd, rd_idx;
  fp_word_t  load_data;
  frm_t      frm_in;
  logic      store_valid;
  fp_word_t  store_data;
  frm_t      frm_out;
  fflags_t   flags_out;
  fp_word_t  rd_data;

  vec_t        vecs[$];
  fp_word_t    model_regs [`FPU_NUM_REGS];  // architectural state in program order
  fflags_t     model_flags;
  frm_t        last_frm;                    // frm_in driven last cycle
  fp_word_t    exp_store;
  logic [31:0] lfsr = 32'he294;
  int          cycles = 0;
  int          limit = 100000;              // replaced once vectors are read
  int          last_issue = 0;              // edge that sampled the newest op
  int          store_issue = 0;
  int          stores_issued = 0;
  int          stores_seen = 0;

  fpu_regfile_top dut (
    .frf_rf, .reset, .op_valid, .op, .rs1, .rs2, .rd, .load_data, .frm_in, .rd_idx,
    .store_valid, .store_data, .frm_out, .flags_out, .rd_data
  );

  initial frf_rf = 1'b0;
  always #50 frf_rf = ~frf_rf;  // 100 ns period

  always @(posedge frf_rf) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, run went past %0d cycles without finishing", limit);
      $display("Regression failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "%s", what);
  endtask

  task automatic check_word(input string name, input fp_word_t got, input fp_word_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_flags(input string name, input fflags_t got, input fflags_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_frm(input string name, input frm_t got, input frm_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // taps for x^32 + x^22 + x^2 + x + 1 shifting left
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output fp_word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  function automatic logic is_nan(input fp_word_t x);
    return (x[30:23] == 8'hff) && (|x[22:0]);
  endfunction

  function automatic logic is_snan(input fp_word_t x);
    return is_nan(x) && !x[22];  // quiet bit clear
  endfunction

  // maps a non-NaN float onto an unsigned scale
  // -0 lands just below +0
  function automatic logic [31:0] order_key(input fp_word_t x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic fp_word_t min_max(input fp_word_t a, input fp_word_t b, input logic pick_max);
    if (is_nan(a) && is_nan(b)) return 32'h7fc0_0000;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    if ((order_key(a) > order_key(b)) == pick_max) return a;
    return b;
  endfunction

  // apply one op to the model in issue order
  task automatic model_issue(input vec_t v);
    fp_word_t a;
    fp_word_t b;
    fp_word_t res;
    a   = (v.op == FP_LOAD) ? v.ld : model_regs[v.rs1];
    b   = model_regs[v.rs2];
    res = a;
    case (v.op)
      FP_SGNJ:  res[31] = b[31];
      FP_SGNJN: res[31] = ~b[31];
      FP_SGNJX: res[31] = a[31] ^ b[31];
      FP_MIN:   res = min_max(a, b, 1'b0);
      FP_MAX:   res = min_max(a, b, 1'b1);
      default:  ;
    endcase
    if (v.op == FP_STORE) begin
      exp_store = b;  // no register or flag change
      stores_issued++;
    end else if (v.op != FP_NOP) begin
      model_regs[v.rd] = res;
      model_flags      = '0;  // flags replaced and never accumulated
      model_flags[4]   = (v.op inside {FP_MIN, FP_MAX}) && (is_snan(a) || is_snan(b));
    end
  endtask

  // one clock of checking registered outputs then driving new inputs
  task automatic cycle_step(input logic valid, input vec_t v);
    @(posedge frf_rf);
    #10;
    check_frm("frm_out", frm_out, last_frm);
    if (store_valid) begin
      if (cycles != store_issue + 1) abort_run("store_valid pulsed in the wrong cycle");
      check_word("store_data", store_data, exp_store);
      stores_seen++;
    end
    op_valid  = valid;
    op        = valid ? v.op : FP_NOP;
    rs1       = v.rs1;
    rs2       = v.rs2;
    rd        = v.rd;
    load_data = v.ld;
    frm_in    = v.frm;
    rd_idx    = v.rd;  // debug read of the destination while idle
    last_frm  = v.frm;
  endtask

  initial begin
    int          fd;
    int          n;
    int          total;
    string       line;
    logic [31:0] f [9];
    fp_word_t    rnd;
    vec_t        v;

    reset     = 1'b1;
    op_valid  = 1'b0;
    op        = FP_NOP;
    rs1       = '0;
    rs2       = '0;
    rd        = '0;
    rd_idx    = '0;
    load_data = '0;
    frm_in    = '0;
    last_frm    = '0;
    model_flags = '0;
    exp_store   = '0;
    v           = '0;
    foreach (model_regs[i]) model_regs[i] = '0;

    fd = $fopen("dv/fpu_regfile_vectors.txt", "r");
    if (fd == 0) abort_run("could not open dv/fpu_regfile_vectors.txt");
    total = 0;
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (line.len() < 9 || line[0] == "#") continue;  // blank or comment
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (n != 9) continue;
      v.op      = fp_op_t'(f[0][2:0]);
      v.rs1     = f[1][4:0];
      v.rs2     = f[2][4:0];
      v.rd      = f[3][4:0];
      v.ld      = f[4];
      v.frm     = f[5][2:0];
      v.idle    = f[6][7:0];
      v.mode    = f[7][2:0];
      v.exp_val = f[8];
      vecs.push_back(v);
      total += 1 + int'(v.idle);
    end
    $fclose(fd);
    if (vecs.size() == 0) abort_run("the vector file holds no vectors");
    limit = 4 * total + 100;

    repeat (16) @(posedge frf_rf);
    #10;
    reset = 1'b0;

    foreach (vecs[k]) begin
      v = vecs[k];
      if (v.mode[0]) begin
        random_word(rnd);
        v.ld = rnd;
      end
      cycle_step(1'b1, v);
      last_issue = cycles + 1;  // sampled at the coming edge
      if (v.op == FP_STORE) store_issue = last_issue;
      model_issue(v);
      repeat (v.idle) cycle_step(1'b0, v);
      while (stores_seen < stores_issued) begin
        if (cycles > last_issue + `FPU_PIPE_DEPTH) abort_run("store_valid never pulsed");
        cycle_step(1'b0, v);
      end
      if (v.mode[2:1] != 2'b00) begin
        cycle_step(1'b0, v);  // at least one idle cycle so rd_idx owns the port
        while (cycles < last_issue + `FPU_PIPE_DEPTH) cycle_step(1'b0, v);
        #50;  // mid-cycle
        check_word("rd_data", rd_data, model_regs[v.rd]);
        if (v.mode[2]) check_word("rd_data", rd_data, v.exp_val);
        check_flags("flags_out", flags_out, model_flags);
      end
    end

    cycle_step(1'b0, v);
    if (stores_seen == stores_issued) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("store pulses seen %0d, stores issued %0d", stores_seen, stores_issued);
      $display("Regression failed");
      $fatal(1, "store count differs");
    end
  end

endmodule

/* src.f */
+incdir+logic
logic/fpu_pkg.sv
logic/f_register_file_if.sv
logic/fp_issue.sv
logic/fp_sign_minmax.sv
logic/fp_writeback.sv
logic/f_register_file.sv
logic/fpu_regfile_top.sv
dv/fpu_regfile_properties.sv
dv/fpu_regfile_tb.sv

/* Bender.yml */
package:
  name: fpu_regfile

sources:
  - include_dirs:
      - logic
    files:
      - logic/fpu_pkg.sv
      - logic/f_register_file_if.sv
      - logic/fp_issue.sv
      - logic/fp_sign_minmax.sv
      - logic/fp_writeback.sv
      - logic/f_register_file.sv
      - logic/fpu_regfile_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/fpu_regfile_properties.sv
      - dv/fpu_regfile_tb.sv

/* dv/fpu_regfile_vectors.txt */
# op rs1 rs2 rd load_data frm idle mode expect, all hex; op 1 ld 2 st 3 sgnj 4 sgnjn 5 sgnjx 6 min 7 max
# mode bit 0 random load_data, bit 1 check rd against the model, bit 2 also against expect
# fixed loads, flags read back as zero
1 00 00 01 3f800000 1 2 6 3f800000
1 00 00 02 c0000000 2 2 6 c0000000
1 00 00 03 80000000 3 2 6 80000000
1 00 00 04 00000000 4 2 6 00000000
1 00 00 05 7fc00001 0 2 6 7fc00001
1 00 00 06 7f800001 1 2 6 7f800001
1 00 00 07 ffc00000 2 2 6 ffc00000
# random operands
1 00 00 0a 00000000 3 2 3 00000000
1 00 00 0b 00000000 4 2 3 00000000
1 00 00 0c 00000000 0 2 3 00000000
1 00 00 0d 00000000 1 2 3 00000000
# sign injection on the random values
3 0a 0b 14 00000000 2 2 2 00000000
4 0c 0d 15 00000000 3 2 2 00000000
5 0a 0c 16 00000000 4 2 2 00000000
5 0b 0b 17 00000000 0 2 2 00000000
4 0d 02 18 00000000 1 2 2 00000000
# min/max with ordered values, signed zeros, quiet and signaling NaN
6 01 02 19 00000000 2 2 6 c0000000
7 01 02 1a 00000000 3 2 6 3f800000
6 03 04 1b 00000000 4 2 6 80000000
7 03 04 1c 00000000 0 2 6 00000000
7 04 03 1c 00000000 1 2 6 00000000
6 05 01 1d 00000000 2 2 6 3f800000
6 07 05 1e 00000000 3 2 6 7fc00000
7 02 06 1e 00000000 4 2 6 c0000000
7 06 05 1f 00000000 0 2 6 7fc00000
# store after an NV result, f2 and the flags must stay put
2 00 02 00 00000000 1 2 0 00000000
0 00 00 02 00000000 2 2 6 c0000000
6 06 06 18 00000000 3 2 6 7fc00000
1 00 00 09 40490fdb 4 2 6 40490fdb
2 00 0a 00 00000000 0 2 0 00000000
# back-to-back independent ops, checked afterwards
1 00 00 08 00000000 1 0 1 00000000
3 01 02 0e 00000000 2 0 0 00000000
7 01 04 0f 00000000 3 0 0 00000000
6 02 04 10 00000000 4 0 0 00000000
2 00 01 00 00000000 0 0 0 00000000
0 00 00 08 00000000 1 0 2 00000000
0 00 00 0e 00000000 1 0 6 bf800000
0 00 00 0f 00000000 1 0 6 3f800000
0 00 00 10 00000000 1 2 6 c0000000
